// ==== cpu_top.f ====
common/cpu_pkg.sv
common/cpu_ifs.sv
rtl/if_stage.sv
rtl/decoder.sv
rtl/gpr.sv
rtl/alu.sv
rtl/mem_ctrl.sv
rtl/wb_stage.sv
spm/spm.sv
rtl/cpu_top.sv
bench/cpu_top_checker.sv
bench/cpu_top_tb.sv

// ==== bench/cpu_top_input.txt ====
# W word_addr data : preload through the test port | G : run until halted
# R name word_addr expected : read back through the test port and compare
W 000 24200400
W 001 24400404
W 002 24600408
W 003 2480040c
W 004 00000000
W 005 04a11000
W 006 08c11000
W 007 0ce11000
W 008 11011000
W 009 15211000
W 00a 19411800
W 00b 1d611800
W 00c 2181ffff
W 00d 28a00440
W 00e 28c00444
W 00f 28e00448
W 010 2900044c
W 011 29200450
W 012 29400454
W 013 29600458
W 014 2980045c
W 015 28800460
W 016 21a00111
W 017 00000000
W 018 00000000
W 019 30210001
W 01a 29a00470
W 01b 2c210002
W 01c 29a00474
W 01d 29a00478
W 01e 29a0047c
W 01f 29a00481
W 020 22000777
W 021 00000000
W 022 00000000
W 023 26000485
W 024 00000000
W 025 00000000
W 026 2a000488
W 027 fc000000
W 028 00000000
W 029 00000000
W 02a 00000000
W 02b 00000000
W 100 12345678
W 101 0f0f00ff
W 102 00000004
W 103 cafef00d
W 11d 0000eeee
W 11e 0000eeee
W 120 5a5a5a5a
G
R tp_readback 100 12345678
R add 110 21435777
R sub 111 03255579
R and 112 02040078
R or 113 1f3f56ff
R xor 114 1d3b5687
R shl 115 23456780
R shr 116 01234567
R addi 117 12345677
R copy 118 cafef00d
R bne_fallthrough 11c 00000111
R beq_squashed 11d 0000eeee
R beq_skipped 11e 0000eeee
R beq_target 11f 00000111
R misaligned_store 120 5a5a5a5a
R misaligned_load 122 00000777

// ==== bench/cpu_top_tb.sv ====
module cpu_top_tb;

    logic            clk;
    logic            rst_n;
    logic            cpu_en;
    cpu_pkg::waddr_t test_spm_addr;
    logic            test_spm_as_n;
    logic            test_spm_rw;
    cpu_pkg::word_t  test_spm_wr_data;
    cpu_pkg::word_t  test_spm_rd_data;
    logic            halted;

    cpu_top uut (
        .clk(clk), .rst_n(rst_n), .cpu_en(cpu_en),
        .test_spm_addr(test_spm_addr), .test_spm_as_n(test_spm_as_n),
        .test_spm_rw(test_spm_rw), .test_spm_wr_data(test_spm_wr_data),
        .test_spm_rd_data(test_spm_rd_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // all test port tasks start and end 1 unit after a rising edge
    task automatic spm_write(input cpu_pkg::waddr_t addr, input cpu_pkg::word_t data);
        test_spm_addr    = addr;
        test_spm_rw      = cpu_pkg::WRITE;
        test_spm_wr_data = data;
        test_spm_as_n    = 1'b0;
        @(posedge clk);
        #1 test_spm_as_n = 1'b1;
    endtask

    task automatic spm_read(input cpu_pkg::waddr_t addr, output cpu_pkg::word_t data);
        test_spm_addr = addr;
        test_spm_rw   = cpu_pkg::READ;
        test_spm_as_n = 1'b0;
        @(posedge clk);
        #1 test_spm_as_n = 1'b1;
        data = test_spm_rd_data; // one cycle after the strobe
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        cpu_en = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #1 cycles++;
            if (cycles > 2000) begin
                $display("timeout: halted never rose within 2000 cycles of the run");
                $display("Simulation failed");
                $fatal(1, "halt timeout");
            end
            check_value("rd_data_gated", 32'h0, test_spm_rd_data);
        end
        repeat (4) @(posedge clk); // let the pipe drain
        #1 check_value("halted_high", 32'h1, {31'h0, halted});
        cpu_en = 1'b0;
    endtask

    initial begin
        int             fd;
        int             code;
        string          line;
        string          cmd;
        string          name;
        int unsigned    addr;
        int unsigned    value;
        cpu_pkg::word_t rd_word;

        rst_n            = 1'b0;
        cpu_en           = 1'b0;
        test_spm_addr    = '0;
        test_spm_as_n    = 1'b1;
        test_spm_rw      = cpu_pkg::READ;
        test_spm_wr_data = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        fd = $fopen("bench/cpu_top_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/cpu_top_input.txt");
            $display("Simulation failed");
            $fatal(1, "no stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0 || line[0] == "#")
                continue;
            if (line[0] == "W") begin
                code = $sscanf(line, "%s %h %h", cmd, addr, value);
                spm_write(addr, value);
            end else if (line[0] == "G") begin
                run_program();
            end else if (line[0] == "R") begin
                code = $sscanf(line, "%s %s %h %h", cmd, name, addr, value);
                spm_read(addr, rd_word);
                check_value(name, value, rd_word);
            end else if (line[0] != "\n") begin
                $display("unknown command in stimulus file: %s", line);
                $display("Simulation failed");
                $fatal(1, "bad stimulus line");
            end
        end
        $fclose(fd);

        if (uut.u_checker.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d assertion failures in the checker", uut.u_checker.fail_count);
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== bench/cpu_top_checker.sv ====
module cpu_top_checker (
    input logic           clk,
    input logic           rst_n,
    input logic           cpu_en,
    input logic           halted,
    input logic           dmem_as_n,
    input logic           miss_align,
    input cpu_pkg::word_t test_spm_rd_data
);

    int fail_count = 0;

    // sticky until reset
    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else begin
            $error("halted fell without a reset");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) cpu_en |-> test_spm_rd_data == '0)
        else begin
            $error("test port read data not zero while the core owns the data port");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(!dmem_as_n && miss_align))
        else begin
            $error("data strobe active on a misaligned access");
            fail_count++;
        end

endmodule

bind cpu_top cpu_top_checker u_checker (
    .clk(clk), .rst_n(rst_n), .cpu_en(cpu_en), .halted(halted),
    .dmem_as_n(cpu_dmem.as_n), .miss_align(miss_align),
    .test_spm_rd_data(test_spm_rd_data)
);

// ==== rtl/cpu_top.sv ====
module cpu_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cpu_en,
    input  cpu_pkg::waddr_t test_spm_addr,
    input  logic            test_spm_as_n,
    input  logic            test_spm_rw,
    input  cpu_pkg::word_t  test_spm_wr_data,
    output cpu_pkg::word_t  test_spm_rd_data,
    output logic            halted
);

    spm_if    imem_bus ();
    spm_if    cpu_dmem ();  // data port as mem_ctrl sees it
    spm_if    spm_dmem ();  // data port after the test mux
    ex_bus_if ex_bus ();
    gpr_rd_if gpr_rd ();

    logic               br_taken;
    cpu_pkg::waddr_t    br_addr;
    cpu_pkg::waddr_t    if_pc;
    cpu_pkg::insn_t     if_insn;
    logic               if_valid;
    cpu_pkg::word_t     alu_out;
    cpu_pkg::word_t     load_data;
    logic               miss_align;
    logic               gpr_we;
    cpu_pkg::reg_addr_t gpr_wr_addr;
    cpu_pkg::word_t     gpr_wr_data;

    if_stage u_if_stage (
        .clk(clk), .rst_n(rst_n), .cpu_en(cpu_en), .halted(halted),
        .br_taken(br_taken), .br_addr(br_addr), .imem(imem_bus.master),
        .if_pc(if_pc), .if_insn(if_insn), .if_valid(if_valid)
    );

    decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .if_pc(if_pc), .if_insn(if_insn), .if_valid(if_valid),
        .gpr_rd(gpr_rd.dec), .ex_bus(ex_bus.src), .br_taken(br_taken), .br_addr(br_addr)
    );

    gpr u_gpr (
        .clk(clk), .rst_n(rst_n), .rd(gpr_rd.rf),
        .we(gpr_we), .wr_addr(gpr_wr_addr), .wr_data(gpr_wr_data)
    );

    alu u_alu (
        .ex_bus(ex_bus.alu_side), .alu_out(alu_out)
    );

    mem_ctrl u_mem_ctrl (
        .ex_bus(ex_bus.mem_side), .alu_out(alu_out), .dmem(cpu_dmem.master),
        .load_data(load_data), .miss_align(miss_align)
    );

    wb_stage u_wb_stage (
        .clk(clk), .rst_n(rst_n), .ex_bus(ex_bus.wb_side), .alu_out(alu_out),
        .miss_align(miss_align), .load_data(load_data), .gpr_we(gpr_we),
        .gpr_wr_addr(gpr_wr_addr), .gpr_wr_data(gpr_wr_data), .halted(halted)
    );

    spm u_spm (
        .clk(clk), .rst_n(rst_n), .if_port(imem_bus.slave), .mem_port(spm_dmem.slave)
    );

    // host owns the data port while the core is stopped
    assign spm_dmem.addr    = cpu_en ? cpu_dmem.addr    : test_spm_addr;
    assign spm_dmem.as_n    = cpu_en ? cpu_dmem.as_n    : test_spm_as_n;
    assign spm_dmem.rw      = cpu_en ? cpu_dmem.rw      : test_spm_rw;
    assign spm_dmem.wr_data = cpu_en ? cpu_dmem.wr_data : test_spm_wr_data;

    assign cpu_dmem.rd_data = spm_dmem.rd_data;
    assign test_spm_rd_data = cpu_en ? '0 : spm_dmem.rd_data;

endmodule

// ==== spm/spm.sv ====
module spm (
    input  logic clk,
    input  logic rst_n,
    spm_if.slave if_port,
    spm_if.slave mem_port
);

    cpu_pkg::word_t mem [cpu_pkg::SPM_DEPTH];
    cpu_pkg::word_t if_rd_q;
    cpu_pkg::word_t mem_rd_q;
    logic           mem_wr;

    assign mem_wr = !mem_port.as_n && (mem_port.rw == cpu_pkg::WRITE);

    // instruction port is read only
    always_ff @(posedge clk) begin
        if (mem_wr)
            mem[mem_port.addr[cpu_pkg::SPM_ADDR_W-1:0]] <= mem_port.wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_rd_q  <= '0;
            mem_rd_q <= '0;
        end else begin
            if (!if_port.as_n && if_port.rw == cpu_pkg::READ)
                if_rd_q <= mem[if_port.addr[cpu_pkg::SPM_ADDR_W-1:0]];
            if (!mem_port.as_n && mem_port.rw == cpu_pkg::READ)
                mem_rd_q <= mem[mem_port.addr[cpu_pkg::SPM_ADDR_W-1:0]];
        end
    end

    assign if_port.rd_data  = if_rd_q;
    assign mem_port.rd_data = mem_rd_q;

endmodule

// ==== rtl/wb_stage.sv ====
module wb_stage (
    input  logic                clk,
    input  logic                rst_n,
    ex_bus_if.wb_side           ex_bus,
    input  cpu_pkg::word_t      alu_out,
    input  logic                miss_align,
    input  cpu_pkg::word_t      load_data,
    output logic                gpr_we,
    output cpu_pkg::reg_addr_t  gpr_wr_addr,
    output cpu_pkg::word_t      gpr_wr_data,
    output logic                halted
);

    cpu_pkg::word_t wb_alu_out;
    logic           wb_load;
    logic           wb_halt;
    logic           ex_load;

    assign ex_load = ex_bus.mem_op == cpu_pkg::MEM_LOAD;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpr_we  <= 1'b0;
            wb_load <= 1'b0;
            wb_halt <= 1'b0;
            halted  <= 1'b0;
        end else begin
            gpr_we  <= ex_bus.gpr_we && !(ex_load && miss_align); // drop misaligned load
            wb_load <= ex_load;
            wb_halt <= ex_bus.valid && ex_bus.is_halt;
            if (wb_halt)
                halted <= 1'b1; // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        wb_alu_out  <= alu_out;
        gpr_wr_addr <= ex_bus.dst_addr;
    end

    assign gpr_wr_data = wb_load ? load_data : wb_alu_out;

endmodule

// ==== rtl/mem_ctrl.sv ====
module mem_ctrl (
    ex_bus_if.mem_side     ex_bus,
    input  cpu_pkg::word_t alu_out,
    spm_if.master          dmem,
    output cpu_pkg::word_t load_data,
    output logic           miss_align
);

    logic is_mem;
    logic access;

    assign is_mem = ex_bus.valid && (ex_bus.mem_op != cpu_pkg::MEM_NONE);

    // word accesses only
    assign miss_align = is_mem && (alu_out[1:0] != 2'b00);
    assign access     = is_mem && !miss_align;

    assign dmem.addr    = alu_out[31:2];
    assign dmem.as_n    = !access;
    assign dmem.rw      = (ex_bus.mem_op == cpu_pkg::MEM_STORE) ? cpu_pkg::WRITE :
                                                                  cpu_pkg::READ;
    assign dmem.wr_data = ex_bus.store_data;

    // valid one cycle after the strobe, i.e. in WB
    assign load_data = dmem.rd_data;

endmodule

// ==== rtl/alu.sv ====
module alu (
    ex_bus_if.alu_side     ex_bus,
    output cpu_pkg::word_t alu_out
);

    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    logic [4:0]     shamt;

    assign a     = ex_bus.alu_in_0;
    assign b     = ex_bus.alu_in_1;
    assign shamt = b[4:0];

    always_comb begin
        case (ex_bus.alu_op)
            cpu_pkg::ALU_ADD:  alu_out = a + b;
            cpu_pkg::ALU_SUB:  alu_out = a - b;
            cpu_pkg::ALU_AND:  alu_out = a & b;
            cpu_pkg::ALU_OR:   alu_out = a | b;
            cpu_pkg::ALU_XOR:  alu_out = a ^ b;
            cpu_pkg::ALU_SHL:  alu_out = a << shamt;
            cpu_pkg::ALU_SHR:  alu_out = a >> shamt; // logical
            cpu_pkg::ALU_PASS: alu_out = a;
            default:           alu_out = '0;
        endcase
    end

endmodule

// ==== rtl/gpr.sv ====
module gpr (
    input  logic               clk,
    input  logic               rst_n,
    gpr_rd_if.rf               rd,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data
);

    cpu_pkg::word_t regs [32];

    // write-through so WB and ID can share a cycle
    assign rd.rd_data_0 = (rd.rd_addr_0 == '0) ? '0 :
                          (we && wr_addr == rd.rd_addr_0) ? wr_data : regs[rd.rd_addr_0];
    assign rd.rd_data_1 = (rd.rd_addr_1 == '0) ? '0 :
                          (we && wr_addr == rd.rd_addr_1) ? wr_data : regs[rd.rd_addr_1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== rtl/decoder.sv ====
module decoder (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::waddr_t if_pc,
    input  cpu_pkg::insn_t  if_insn,
    input  logic            if_valid,
    gpr_rd_if.dec           gpr_rd,
    ex_bus_if.src           ex_bus,
    output logic            br_taken,
    output cpu_pkg::waddr_t br_addr
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::word_t     imm_sext;
    logic               rd_is_src;
    logic               src_eq;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::word_t     alu_in_1;
    cpu_pkg::mem_op_t   mem_op;
    logic               gpr_we;
    logic               is_halt;

    assign opcode   = if_insn[31:26];
    assign rd       = if_insn[25:21];
    assign rs1      = if_insn[20:16];
    assign rs2      = if_insn[15:11];
    assign imm_sext = {{16{if_insn[15]}}, if_insn[15:0]};

    // store and branches need the imm field, so their second source sits in the rd field
    assign rd_is_src = (opcode == cpu_pkg::OP_STORE) || (opcode == cpu_pkg::OP_BEQ) ||
                       (opcode == cpu_pkg::OP_BNE);

    assign gpr_rd.rd_addr_0 = rs1;
    assign gpr_rd.rd_addr_1 = rd_is_src ? rd : rs2;

    assign src_eq   = gpr_rd.rd_data_0 == gpr_rd.rd_data_1;
    assign br_taken = if_valid && (((opcode == cpu_pkg::OP_BEQ) && src_eq) ||
                                   ((opcode == cpu_pkg::OP_BNE) && !src_eq));
    assign br_addr  = if_pc + 30'd1 + imm_sext[29:0]; // relative to next insn

    always_comb begin
        alu_op   = cpu_pkg::ALU_PASS;
        alu_in_1 = gpr_rd.rd_data_1;
        mem_op   = cpu_pkg::MEM_NONE;
        gpr_we   = 1'b0;
        is_halt  = 1'b0;
        case (opcode)
            cpu_pkg::OP_ADD: begin alu_op = cpu_pkg::ALU_ADD; gpr_we = 1'b1; end
            cpu_pkg::OP_SUB: begin alu_op = cpu_pkg::ALU_SUB; gpr_we = 1'b1; end
            cpu_pkg::OP_AND: begin alu_op = cpu_pkg::ALU_AND; gpr_we = 1'b1; end
            cpu_pkg::OP_OR:  begin alu_op = cpu_pkg::ALU_OR;  gpr_we = 1'b1; end
            cpu_pkg::OP_XOR: begin alu_op = cpu_pkg::ALU_XOR; gpr_we = 1'b1; end
            cpu_pkg::OP_SHL: begin alu_op = cpu_pkg::ALU_SHL; gpr_we = 1'b1; end
            cpu_pkg::OP_SHR: begin alu_op = cpu_pkg::ALU_SHR; gpr_we = 1'b1; end
            cpu_pkg::OP_ADDI: begin
                alu_op   = cpu_pkg::ALU_ADD;
                alu_in_1 = imm_sext;
                gpr_we   = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                alu_op   = cpu_pkg::ALU_ADD; // byte address rs1 + imm
                alu_in_1 = imm_sext;
                mem_op   = cpu_pkg::MEM_LOAD;
                gpr_we   = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                alu_op   = cpu_pkg::ALU_ADD;
                alu_in_1 = imm_sext;
                mem_op   = cpu_pkg::MEM_STORE;
            end
            cpu_pkg::OP_HALT: is_halt = 1'b1;
            default: ; // nop, branches resolved above
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_bus.valid   <= 1'b0;
            ex_bus.gpr_we  <= 1'b0;
            ex_bus.mem_op  <= cpu_pkg::MEM_NONE;
            ex_bus.is_halt <= 1'b0;
        end else begin
            ex_bus.valid   <= if_valid;
            ex_bus.gpr_we  <= if_valid && gpr_we;
            ex_bus.mem_op  <= if_valid ? mem_op : cpu_pkg::MEM_NONE;
            ex_bus.is_halt <= if_valid && is_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_bus.alu_op     <= alu_op;
        ex_bus.alu_in_0   <= gpr_rd.rd_data_0;
        ex_bus.alu_in_1   <= alu_in_1;
        ex_bus.store_data <= gpr_rd.rd_data_1;
        ex_bus.dst_addr   <= rd;
    end

endmodule

// ==== rtl/if_stage.sv ====
module if_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cpu_en,
    input  logic            halted,
    input  logic            br_taken,
    input  cpu_pkg::waddr_t br_addr,
    spm_if.master           imem,
    output cpu_pkg::waddr_t if_pc,
    output cpu_pkg::insn_t  if_insn,
    output logic            if_valid
);

    cpu_pkg::waddr_t pc;
    logic            fetch;

    assign fetch = cpu_en && !halted;

    assign imem.addr    = pc;
    assign imem.as_n    = !fetch;
    assign imem.rw      = cpu_pkg::READ;
    assign imem.wr_data = '0;

    assign if_insn = imem.rd_data; // spm read is registered

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= cpu_pkg::RESET_PC;
            if_valid <= 1'b0;
        end else begin
            if_valid <= fetch && !br_taken; // word fetched behind a taken branch is dropped
            if (br_taken)
                pc <= br_addr;
            else if (fetch)
                pc <= pc + 30'd1;
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc; // pc that goes with the returning word
    end

endmodule

// ==== common/cpu_ifs.sv ====
// one SPM port, strobe active low
interface spm_if;
    cpu_pkg::waddr_t addr;
    logic            as_n;
    logic            rw;
    cpu_pkg::word_t  wr_data;
    cpu_pkg::word_t  rd_data;

    modport master (output addr, as_n, rw, wr_data, input rd_data);
    modport slave  (input addr, as_n, rw, wr_data, output rd_data);
endinterface

// ID/EX pipeline register contents
interface ex_bus_if;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::word_t     alu_in_0;
    cpu_pkg::word_t     alu_in_1;
    cpu_pkg::mem_op_t   mem_op;
    cpu_pkg::word_t     store_data;
    cpu_pkg::reg_addr_t dst_addr;
    logic               gpr_we;
    logic               is_halt;
    logic               valid;

    modport src (output alu_op, alu_in_0, alu_in_1, mem_op, store_data, dst_addr,
                 gpr_we, is_halt, valid);
    modport alu_side (input alu_op, alu_in_0, alu_in_1);
    modport mem_side (input mem_op, store_data, valid);
    modport wb_side  (input mem_op, dst_addr, gpr_we, is_halt, valid);
endinterface

interface gpr_rd_if;
    cpu_pkg::reg_addr_t rd_addr_0;
    cpu_pkg::reg_addr_t rd_addr_1;
    cpu_pkg::word_t     rd_data_0;
    cpu_pkg::word_t     rd_data_1;

    modport dec (output rd_addr_0, rd_addr_1, input rd_data_0, rd_data_1);
    modport rf  (input rd_addr_0, rd_addr_1, output rd_data_0, rd_data_1);
endinterface

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] insn_t;      // op[31:26] rd[25:21] rs1[20:16] rs2[15:11] imm[15:0]
    typedef logic [29:0] waddr_t;     // byte address without bits 1:0
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_op_t;

    localparam opcode_t OP_NOP   = 6'h00;
    localparam opcode_t OP_ADD   = 6'h01;
    localparam opcode_t OP_SUB   = 6'h02;
    localparam opcode_t OP_AND   = 6'h03;
    localparam opcode_t OP_OR    = 6'h04;
    localparam opcode_t OP_XOR   = 6'h05;
    localparam opcode_t OP_SHL   = 6'h06;
    localparam opcode_t OP_SHR   = 6'h07;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LOAD  = 6'h09;
    localparam opcode_t OP_STORE = 6'h0a;
    localparam opcode_t OP_BEQ   = 6'h0b;
    localparam opcode_t OP_BNE   = 6'h0c;
    localparam opcode_t OP_HALT  = 6'h3f;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SHL  = 4'd5;
    localparam alu_op_t ALU_SHR  = 4'd6;
    localparam alu_op_t ALU_PASS = 4'd7;

    localparam mem_op_t MEM_NONE  = 2'd0;
    localparam mem_op_t MEM_LOAD  = 2'd1;
    localparam mem_op_t MEM_STORE = 2'd2;

    localparam int SPM_DEPTH  = 1024;
    localparam int SPM_ADDR_W = $clog2(SPM_DEPTH);

    localparam waddr_t RESET_PC = '0;

    // rw level of a strobe
    localparam logic READ  = 1'b1;
    localparam logic WRITE = 1'b0;

endpackage
